// File: rtl/vcop_pkg.sv
`default_nettype none

package vcop_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    parameter int XLEN       = 32;  // scalar word
    parameter int REG_ADDR_W = 5;   // 32 regs, both files

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////
    // major opcode, instr[6:0]
    typedef enum logic [6:0] {
        OP_OTHER    = 7'b0000000,
        OP_STORE_FP = 7'b0100111,  // vse lives here
        OP_V        = 7'b1010111   // arith + vsetvli
    } opcode_e;

    // OP_V funct3, only the integer forms
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPCFG = 3'b111
    } funct3_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,  // vs2 - a
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    // where operand a comes from
    typedef enum logic [1:0] {
        OPSEL_VREG,
        OPSEL_XREG,
        OPSEL_IMM
    } opsel_e;

    // vsew field of vtype
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2
    } sew_e;

    //////////////////////////////////////////////////
    // bundles
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                  vreg_wr;     // writes vd
        logic                  is_vconfig;
        logic                  is_store;
        alu_op_e               alu_op;
        opsel_e                opsel;
        logic [REG_ADDR_W-1:0] vd;
        logic [REG_ADDR_W-1:0] vs1;
        logic [REG_ADDR_W-1:0] vs2;
        logic [REG_ADDR_W-1:0] vs3;         // store source
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [4:0]            imm;         // zero-extended later
        sew_e                  sew;         // requested by vsetvli
    } vuop_t;

    // live vtype/vl
    typedef struct packed {
        sew_e            sew;
        logic [XLEN-1:0] vl;
    } vcfg_t;

endpackage

`default_nettype wire

// File: rtl/vcop_decoder.sv
`default_nettype none

module vcop_decoder (
    input  logic [vcop_pkg::XLEN-1:0] instr,
    output vcop_pkg::vuop_t           uop
);

    logic              alu_ok;  // funct6 is one we implement
    vcop_pkg::alu_op_e alu_op;
    logic              width_ok;

    // funct6 -> alu op
    always_comb begin
        alu_ok = 1'b1;
        case (instr[31:26])
            6'b000000: alu_op = vcop_pkg::ALU_ADD;
            6'b000010: alu_op = vcop_pkg::ALU_SUB;
            6'b001001: alu_op = vcop_pkg::ALU_AND;
            6'b001010: alu_op = vcop_pkg::ALU_OR;
            6'b001011: alu_op = vcop_pkg::ALU_XOR;
            default: begin
                alu_op = vcop_pkg::ALU_ADD;
                alu_ok = 1'b0;
            end
        endcase
    end

    // vse8/16/32 width codes
    assign width_ok = (instr[14:12] == 3'b000) || (instr[14:12] == 3'b101) ||
                      (instr[14:12] == 3'b110);

    always_comb begin
        uop        = '0;  // x or zero word lands here and stays a no-op
        uop.alu_op = alu_op;
        uop.opsel  = vcop_pkg::OPSEL_VREG;
        uop.sew    = vcop_pkg::SEW_8;
        uop.vd     = instr[11:7];
        uop.vs3    = instr[11:7];   // same slot as vd
        uop.vs1    = instr[19:15];
        uop.rs1    = instr[19:15];
        uop.imm    = instr[19:15];
        uop.vs2    = instr[24:20];
        uop.rs2    = instr[24:20];
        case (instr[6:0])
            vcop_pkg::OP_V: begin
                case (instr[14:12])
                    vcop_pkg::OPIVV: uop.vreg_wr = alu_ok;
                    vcop_pkg::OPIVX: begin
                        uop.opsel   = vcop_pkg::OPSEL_XREG;
                        uop.vreg_wr = alu_ok;
                    end
                    vcop_pkg::OPIVI: begin
                        uop.opsel   = vcop_pkg::OPSEL_IMM;
                        uop.vreg_wr = alu_ok;
                    end
                    vcop_pkg::OPCFG: begin
                        // vsetvli only, vsew in 25:23, reserved sews ignored
                        if (!instr[31] && !instr[25] && instr[24:23] != 2'b11) begin
                            uop.is_vconfig = 1'b1;
                            uop.sew        = vcop_pkg::sew_e'(instr[24:23]);
                        end
                    end
                    default: ;
                endcase
            end
            vcop_pkg::OP_STORE_FP: begin
                // unit stride only: mew=0, mop=00, sumop=0
                uop.is_store = width_ok && (instr[28:26] == 3'b000) &&
                               (instr[24:20] == 5'b00000);
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/vcop_vcfg.sv
`default_nettype none

module vcop_vcfg #(
    parameter int VLEN = 128
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  vcop_pkg::vuop_t           uop,
    input  logic [vcop_pkg::XLEN-1:0] avl,      // rs1 value
    output vcop_pkg::vcfg_t           cfg,
    output logic [VLEN/8-1:0]         body_be
);

    localparam int unsigned VLMAX_8  = VLEN / 8;
    localparam int unsigned VLMAX_16 = VLEN / 16;
    localparam int unsigned VLMAX_32 = VLEN / 32;

    logic [vcop_pkg::XLEN-1:0] vlmax;  // for the requested sew

    always_comb begin
        case (uop.sew)
            vcop_pkg::SEW_16: vlmax = VLMAX_16;
            vcop_pkg::SEW_32: vlmax = VLMAX_32;
            default:          vlmax = VLMAX_8;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.sew <= vcop_pkg::SEW_8;
            cfg.vl  <= '0;  // nothing active out of reset
        end else if (uop.is_vconfig) begin
            cfg.sew <= uop.sew;
            cfg.vl  <= (avl < vlmax) ? avl : vlmax;  // clamp
        end
    end

    // byte i belongs to element i >> sew
    always_comb begin
        for (int unsigned i = 0; i < VLEN / 8; i++) begin
            body_be[i] = ((i >> cfg.sew) < cfg.vl);
        end
    end

endmodule

`default_nettype wire

// File: rtl/vcop_vregfile.sv
`default_nettype none

module vcop_vregfile #(
    parameter int VLEN = 128
) (
    input  logic              clk,
    input  logic              arst_n,
    input  vcop_pkg::vuop_t   uop,
    input  logic [VLEN-1:0]   wr_data,   // alu result
    input  logic [VLEN/8-1:0] body_be,
    output logic [VLEN-1:0]   vs1_data,
    output logic [VLEN-1:0]   vs2_data,
    output logic [VLEN-1:0]   vs3_data
);

    localparam int NREGS = 1 << vcop_pkg::REG_ADDR_W;
    localparam int NB    = VLEN / 8;

    logic [VLEN-1:0] regs [NREGS];

    // byte-wise write, tail bytes left alone
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (uop.vreg_wr) begin
            for (int b = 0; b < NB; b++) begin
                if (body_be[b]) begin
                    regs[uop.vd][b*8 +: 8] <= wr_data[b*8 +: 8];
                end
            end
        end
    end

    // async reads
    assign vs1_data = regs[uop.vs1];  // op a source
    assign vs2_data = regs[uop.vs2];  // op b
    assign vs3_data = regs[uop.vs3];  // store data

endmodule

`default_nettype wire

// File: rtl/vcop_operand_sel.sv
`default_nettype none

module vcop_operand_sel #(
    parameter int VLEN = 128
) (
    input  vcop_pkg::vuop_t           uop,
    input  vcop_pkg::vcfg_t           cfg,
    input  logic [VLEN-1:0]           vs1_data,
    input  logic [vcop_pkg::XLEN-1:0] xreg,      // rs1 value
    output logic [VLEN-1:0]           op_a
);

    logic [vcop_pkg::XLEN-1:0] scalar;  // value to splat

    // imm is zero-extended, not sign-extended
    assign scalar = (uop.opsel == vcop_pkg::OPSEL_IMM) ?
                    {{(vcop_pkg::XLEN-5){1'b0}}, uop.imm} : xreg;

    always_comb begin
        if (uop.opsel == vcop_pkg::OPSEL_VREG) begin
            op_a = vs1_data;
        end else begin
            // truncate to sew, repeat per element
            case (cfg.sew)
                vcop_pkg::SEW_16: op_a = {(VLEN/16){scalar[15:0]}};
                vcop_pkg::SEW_32: op_a = {(VLEN/32){scalar[31:0]}};
                default:          op_a = {(VLEN/8){scalar[7:0]}};
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vcop_alu_lanes.sv
`default_nettype none

module vcop_alu_lanes #(
    parameter int VLEN = 128
) (
    input  vcop_pkg::vuop_t uop,
    input  vcop_pkg::vcfg_t cfg,
    input  logic [VLEN-1:0] op_a,
    input  logic [VLEN-1:0] op_b,    // vs2
    output logic [VLEN-1:0] result
);

    logic is_sub;  // vs2 + ~a + 1

    assign is_sub = (uop.alu_op == vcop_pkg::ALU_SUB);

    //////////////////////////////////////////////////
    // byte ripple, carry cut at element starts
    //////////////////////////////////////////////////
    always_comb begin
        logic       carry;   // stays inside one element
        logic [7:0] a_byte;
        logic [7:0] b_byte;
        logic [8:0] sum;
        carry = 1'b0;
        for (int b = 0; b < VLEN / 8; b++) begin
            a_byte = op_a[b*8 +: 8];
            b_byte = op_b[b*8 +: 8];
            // first byte of an element, 1/2/4 bytes per element by sew
            if ((b % (1 << cfg.sew)) == 0) begin
                carry = is_sub;  // the +1 of two's complement
            end
            sum   = {1'b0, b_byte} + {1'b0, (is_sub ? ~a_byte : a_byte)} + {8'd0, carry};
            carry = sum[8];
            case (uop.alu_op)
                vcop_pkg::ALU_AND: result[b*8 +: 8] = b_byte & a_byte;
                vcop_pkg::ALU_OR:  result[b*8 +: 8] = b_byte | a_byte;
                vcop_pkg::ALU_XOR: result[b*8 +: 8] = b_byte ^ a_byte;
                default:           result[b*8 +: 8] = sum[7:0];  // add, sub
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/vcop_store_port.sv
`default_nettype none

module vcop_store_port #(
    parameter int VLEN = 128
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  vcop_pkg::vuop_t           uop,
    input  logic [vcop_pkg::XLEN-1:0] addr,          // rs1 base
    input  logic [VLEN-1:0]           vs3_data,
    input  logic [VLEN/8-1:0]         body_be,
    output logic                      dm_v_write,
    output logic [vcop_pkg::XLEN-1:0] data_addr,
    output logic [VLEN-1:0]           v_store_data,
    output logic [VLEN/8-1:0]         store_byte_en
);

    // one pulse per store, back to back allowed
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dm_v_write <= 1'b0;
        end else begin
            dm_v_write <= uop.is_store;
        end
    end

    // payload only loads on a store
    always_ff @(posedge clk) begin
        if (uop.is_store) begin
            data_addr     <= addr;
            v_store_data  <= vs3_data;  // whole register
            store_byte_en <= body_be;   // body bytes only
        end
    end

endmodule

`default_nettype wire

// File: rtl/vcop_top.sv
`default_nettype none

module vcop_top #(
    parameter int VLEN = 128
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [vcop_pkg::XLEN-1:0]       op_instr_base,    // one instr per cycle
    // scalar register reads from the base core
    output logic [vcop_pkg::REG_ADDR_W-1:0] v_rd_xreg_addr1,
    output logic [vcop_pkg::REG_ADDR_W-1:0] v_rd_xreg_addr2,
    input  logic [vcop_pkg::XLEN-1:0]       xreg_out1,        // same cycle
    input  logic [vcop_pkg::XLEN-1:0]       xreg_out2,
    // data memory write side
    output logic                            dm_v_write,
    output logic [vcop_pkg::XLEN-1:0]       data_addr,
    output logic [VLEN-1:0]                 v_store_data,
    output logic [VLEN/8-1:0]               store_byte_en
);

    vcop_pkg::vuop_t   uop;
    vcop_pkg::vcfg_t   cfg;
    logic [VLEN/8-1:0] body_be;
    logic [VLEN-1:0]   vs1_data, vs2_data, vs3_data;
    logic [VLEN-1:0]   op_a;
    logic [VLEN-1:0]   alu_res;

    assign v_rd_xreg_addr1 = uop.rs1;
    assign v_rd_xreg_addr2 = uop.rs2;

    //////////////////////////////////////////////////
    // decode and config
    //////////////////////////////////////////////////
    vcop_decoder u_dec (.instr(op_instr_base), .uop(uop));

    vcop_vcfg #(.VLEN(VLEN)) u_vcfg (
        .clk(clk), .arst_n(arst_n), .uop(uop), .avl(xreg_out1),
        .cfg(cfg), .body_be(body_be)
    );

    //////////////////////////////////////////////////
    // datapath
    //////////////////////////////////////////////////
    vcop_vregfile #(.VLEN(VLEN)) u_vrf (
        .clk(clk), .arst_n(arst_n), .uop(uop), .wr_data(alu_res), .body_be(body_be),
        .vs1_data(vs1_data), .vs2_data(vs2_data), .vs3_data(vs3_data)
    );

    vcop_operand_sel #(.VLEN(VLEN)) u_opsel (
        .uop(uop), .cfg(cfg), .vs1_data(vs1_data), .xreg(xreg_out1), .op_a(op_a)
    );

    vcop_alu_lanes #(.VLEN(VLEN)) u_alu (
        .uop(uop), .cfg(cfg), .op_a(op_a), .op_b(vs2_data), .result(alu_res)
    );

    vcop_store_port #(.VLEN(VLEN)) u_st (
        .clk(clk), .arst_n(arst_n), .uop(uop), .addr(xreg_out1), .vs3_data(vs3_data),
        .body_be(body_be), .dm_v_write(dm_v_write), .data_addr(data_addr),
        .v_store_data(v_store_data), .store_byte_en(store_byte_en)
    );

endmodule

`default_nettype wire

// File: dv/vcop_sva.sv
`default_nettype none

module vcop_sva (
    input logic clk,
    input logic arst_n,
    input logic is_store,     // decoded vse this cycle
    input logic dm_v_write
);

    int fails = 0;  // picked up by the testbench at the end

    //////////////////////////////////////////////////
    // store strobe rules
    //////////////////////////////////////////////////
    reset_quiet: assert property (@(posedge clk) !arst_n |-> !dm_v_write)
        else begin
            fails++;
            $error("dm_v_write is high while reset is asserted");
        end

    // no pulse without a store one cycle earlier
    pulse_needs_store: assert property (
        @(posedge clk) disable iff (!arst_n) dm_v_write |-> $past(is_store))
        else begin
            fails++;
            $error("dm_v_write pulsed with no store in the cycle before");
        end

    store_gives_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) is_store |=> dm_v_write)
        else begin
            fails++;
            $error("store was not followed by a dm_v_write pulse");
        end

endmodule

bind vcop_store_port vcop_sva u_sva (
    .clk(clk), .arst_n(arst_n), .is_store(uop.is_store), .dm_v_write(dm_v_write)
);

`default_nettype wire

// File: dv/vcop_tb.sv
`default_nettype none

module vcop_tb;

    localparam int VLEN    = 128;
    localparam int TBL_MAX = 256;

    typedef struct packed {
        logic [31:0]       instr;
        logic              st;     // store pulse expected next cycle
        logic [31:0]       addr;
        logic [VLEN-1:0]   data;
        logic [VLEN/8-1:0] be;
    } entry_t;

    logic              clk;
    logic              arst_n;
    logic [31:0]       op_instr_base;
    logic [4:0]        v_rd_xreg_addr1, v_rd_xreg_addr2;
    logic [31:0]       xreg_out1, xreg_out2;
    logic              dm_v_write;
    logic [31:0]       data_addr;
    logic [VLEN-1:0]   v_store_data;
    logic [VLEN/8-1:0] store_byte_en;

    entry_t          tbl [TBL_MAX];
    int              tbl_len = 0;
    int              errors  = 0;
    int              cycles  = 0;
    logic [31:0]     rng     = 32'h9017;
    logic [31:0]     xregs [32];     // scalar side, read only
    logic [VLEN-1:0] mvreg [32];     // reference vector regs
    logic [31:0]     mvl     = 0;
    int              mew     = 8;    // element width in bits

    vcop_top #(.VLEN(VLEN)) dut (
        .clk(clk), .arst_n(arst_n), .op_instr_base(op_instr_base),
        .v_rd_xreg_addr1(v_rd_xreg_addr1), .v_rd_xreg_addr2(v_rd_xreg_addr2),
        .xreg_out1(xreg_out1), .xreg_out2(xreg_out2), .dm_v_write(dm_v_write),
        .data_addr(data_addr), .v_store_data(v_store_data), .store_byte_en(store_byte_en)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // encoders and reference model
    //////////////////////////////////////////////////
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] vsetvli_word(input logic [4:0] rs1, input logic [1:0] sew);
        return {6'b0, 1'b0, sew, 3'b000, rs1, 3'b111, 5'd0, 7'h57};  // lmul 1, rd x0
    endfunction

    function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                               input logic [4:0] vd, input logic [4:0] vs2,
                                               input logic [4:0] src);
        return {f6, 1'b1, vs2, src, f3, vd, 7'h57};  // vm=1, unmasked
    endfunction

    function automatic logic [31:0] vse_word(input logic [4:0] vs3, input logic [4:0] rs1);
        return {3'b000, 1'b0, 2'b00, 1'b1, 5'd0, rs1, 3'b000, vs3, 7'h27};
    endfunction

    function automatic logic [5:0] alu_funct6(input int k);
        case (k)
            0: return 6'h00;  // add
            1: return 6'h02;  // sub
            2: return 6'h09;
            3: return 6'h0a;
            default: return 6'h0b;
        endcase
    endfunction

    function automatic logic [2:0] form_funct3(input int f);
        return (f == 0) ? 3'b000 : (f == 1) ? 3'b100 : 3'b011;  // vv, vx, vi
    endfunction

    function automatic logic [31:0] elem_op(input logic [5:0] f6, input logic [31:0] b,
                                            input logic [31:0] a);
        case (f6)
            6'h00: return b + a;
            6'h02: return b - a;  // vs2 minus a
            6'h09: return b & a;
            6'h0a: return b | a;
            default: return b ^ a;
        endcase
    endfunction

    function automatic logic [31:0] get_elem(input logic [VLEN-1:0] v, input int el,
                                             input int ew);
        logic [31:0] x;
        x = '0;
        for (int j = 0; j < ew; j++) x[j] = v[el*ew + j];
        return x;
    endfunction

    // runs one word through the model, then files it with its expected store
    task automatic add_entry(input logic [31:0] w);
        entry_t          e;
        logic [31:0]     a, r, vlmax;
        logic [VLEN-1:0] res;
        e       = '0;
        e.instr = w;
        if (w[6:0] == 7'h57 && w[14:12] == 3'b111) begin
            mew   = 8 << w[24:23];
            vlmax = VLEN / mew;
            mvl   = (xregs[w[19:15]] < vlmax) ? xregs[w[19:15]] : vlmax;  // clamp
        end else if (w[6:0] == 7'h57) begin
            res = mvreg[w[11:7]];  // tail undisturbed
            for (int el = 0; el < VLEN / mew; el++) begin
                if (el < mvl) begin
                    case (w[14:12])
                        3'b000:  a = get_elem(mvreg[w[19:15]], el, mew);
                        3'b100:  a = xregs[w[19:15]];
                        default: a = {27'd0, w[19:15]};  // zero-extended imm
                    endcase
                    r = elem_op(w[31:26], get_elem(mvreg[w[24:20]], el, mew), a);
                    for (int j = 0; j < mew; j++) res[el*mew + j] = r[j];  // wraps
                end
            end
            mvreg[w[11:7]] = res;
        end else if (w[6:0] == 7'h27) begin
            e.st   = 1'b1;
            e.addr = xregs[w[19:15]];
            e.data = mvreg[w[11:7]];
            for (int i = 0; i < VLEN / 8; i++) e.be[i] = ((i / (mew / 8)) < mvl);
        end
        tbl[tbl_len] = e;
        tbl_len++;
    endtask

    task automatic check_store(input int idx, input logic [31:0] cur);
        entry_t e;
        e = tbl[idx];
        assert (v_rd_xreg_addr1 === cur[19:15] && v_rd_xreg_addr2 === cur[24:20])
            else begin
                errors++;
                $display("Mismatch at %0t: xreg read addresses %0d/%0d for word %h",
                         $time, v_rd_xreg_addr1, v_rd_xreg_addr2, cur);
            end
        assert (dm_v_write === e.st)
            else begin
                errors++;
                $display("Mismatch at %0t: entry %0d dm_v_write %b, expected %b",
                         $time, idx, dm_v_write, e.st);
            end
        if (e.st) begin
            assert (data_addr === e.addr && store_byte_en === e.be)
                else begin
                    errors++;
                    $display("Mismatch at %0t: entry %0d addr %h be %h, expected %h %h",
                             $time, idx, data_addr, store_byte_en, e.addr, e.be);
                end
            assert (v_store_data === e.data)
                else begin
                    errors++;
                    $display("Mismatch at %0t: entry %0d data %h, expected %h",
                             $time, idx, v_store_data, e.data);
                end
        end
    endtask

    //////////////////////////////////////////////////
    // run limit
    //////////////////////////////////////////////////
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > tbl_len + 20) begin
            $display("timeout: table not finished within %0d cycles", tbl_len + 20);
            $display("mismatches: %0d, assertion failures: %0d", errors, dut.u_st.u_sva.fails);
            $display("TB FAILED");
            $finish;
        end
    end

    initial begin
        logic [31:0] cur;
        logic [4:0]  src;
        clk           = 1'b0;
        arst_n        = 1'b0;
        op_instr_base = '0;
        xreg_out1     = '0;
        xreg_out2     = '0;
        for (int i = 0; i < 32; i++) begin
            rng      = lcg_next(rng);
            xregs[i] = rng;
            mvreg[i] = '0;
        end
        xregs[0]  = 32'd0;
        xregs[28] = 32'd3;
        xregs[29] = 32'd5;
        xregs[31] = 32'd1000;  // above any vlmax

        // vl still 0 out of reset
        add_entry(vse_word(5'd0, 5'd5));
        add_entry(vsetvli_word(5'd31, 2'd0));
        add_entry(vse_word(5'd0, 5'd6));
        add_entry(vsetvli_word(5'd29, 2'd1));  // 5 x 16 bit
        add_entry(vse_word(5'd0, 5'd7));
        // preload v1..v9 with mixed data
        for (int r = 1; r < 10; r++) begin
            add_entry(vsetvli_word(5'd31, 2'(r % 3)));
            add_entry(arith_word(6'h00, 3'b100, 5'(r), 5'(r - 1), 5'(r)));
            add_entry(arith_word(6'h0a, 3'b100, 5'(r), 5'(r), 5'(r + 10)));
        end
        // every op, form and sew, each result stored
        for (int s = 0; s < 3; s++) begin
            add_entry(vsetvli_word(5'd31, 2'(s)));
            for (int k = 0; k < 5; k++) begin
                for (int f = 0; f < 3; f++) begin
                    rng = lcg_next(rng);
                    src = (f == 0) ? 5'((rng[20:16] % 9) + 1) : rng[20:16];
                    add_entry(arith_word(alu_funct6(k), form_funct3(f), 5'd10,
                                         5'((rng[27:24] % 9) + 1), src));
                    add_entry(vse_word(5'd10, 5'd5));
                end
            end
        end
        // short vl, tail keeps old bytes
        add_entry(vsetvli_word(5'd29, 2'd1));
        add_entry(arith_word(6'h00, 3'b000, 5'd4, 5'd5, 5'd6));
        add_entry(vse_word(5'd4, 5'd8));
        add_entry(vsetvli_word(5'd28, 2'd2));
        add_entry(arith_word(6'h02, 3'b011, 5'd5, 5'd6, 5'd7));  // vsub.vi
        add_entry(vse_word(5'd5, 5'd8));
        // dependent chain, store right behind the write
        add_entry(vsetvli_word(5'd31, 2'd0));
        add_entry(arith_word(6'h00, 3'b000, 5'd20, 5'd1, 5'd2));
        add_entry(arith_word(6'h0b, 3'b000, 5'd21, 5'd20, 5'd3));
        add_entry(arith_word(6'h02, 3'b100, 5'd22, 5'd21, 5'd9));
        add_entry(vse_word(5'd22, 5'd5));
        add_entry(vse_word(5'd21, 5'd6));  // back to back pulses
        add_entry(32'h0000_0000);

        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // entry k goes in at one edge, its store shows after the next
        for (int k = 0; k <= tbl_len; k++) begin
            @(posedge clk);
            cur = (k < tbl_len) ? tbl[k].instr : 32'd0;
            op_instr_base <= cur;
            xreg_out1     <= xregs[cur[19:15]];
            xreg_out2     <= xregs[cur[24:20]];
            if (k > 0) begin
                @(negedge clk);
                check_store(k - 1, cur);
            end
        end
        @(posedge clk);
        $display("mismatches: %0d, assertion failures: %0d", errors, dut.u_st.u_sva.fails);
        if (errors == 0 && dut.u_st.u_sva.fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vcop.f
rtl/vcop_pkg.sv
rtl/vcop_decoder.sv
rtl/vcop_vcfg.sv
rtl/vcop_vregfile.sv
rtl/vcop_operand_sel.sv
rtl/vcop_alu_lanes.sv
rtl/vcop_store_port.sv
rtl/vcop_top.sv
dv/vcop_sva.sv
dv/vcop_tb.sv
